// File: files.f
+incdir+.
line_pkg.sv
line_setup.sv
line_engine.sv
line_write_arb.sv
line_raster_top.sv
tb_line_raster.sv

// File: line_defs.svh
`ifndef LINE_DEFS_SVH
`define LINE_DEFS_SVH

// Number of parallel line engines, 1 to 4
`define LINE_NUM_ENGINES 2

// Screen coordinate width
`define LINE_COORD_W 10

// Signed Bresenham error and delta width
`define LINE_ERR_W 16

// Address FIFO word width
`define LINE_ADDR_W 31

// Write-data mask width, one bit per byte of a 128-bit beat
`define LINE_MASK_W 16

`endif

// File: line_engine.sv
module line_engine (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  line_pkg::coord_t start_x,
  input  line_pkg::coord_t start_y,
  input  line_pkg::coord_t end_x,
  input  line_pkg::err_t   delta_x,
  input  line_pkg::err_t   delta_y,
  input  line_pkg::err_t   err_init,
  input  logic             ystep_neg,
  input  logic             steep,
  input  line_pkg::color_t color,
  input  logic [5:0]       frame_sel,
  input  logic             pix_done,
  output logic             busy,
  output logic             pix_valid,
  output line_pkg::coord_t pix_col,
  output line_pkg::coord_t pix_row,
  output line_pkg::color_t pix_color,
  output logic [5:0]       pix_frame
);

  // Walk position, in the swapped frame
  line_pkg::coord_t x_r;
  line_pkg::coord_t y_r;
  line_pkg::coord_t end_x_r;
  line_pkg::err_t   err_r;

  // Line constants latched at start
  line_pkg::err_t   dx_r;
  line_pkg::err_t   dy_r;
  logic             yneg_r;
  logic             steep_r;
  line_pkg::color_t color_r;
  logic [5:0]       frame_r;

  logic busy_r;
  logic valid_r;

  logic           load;
  logic           step;
  logic           last_pix;
  line_pkg::err_t err_step;

  assign load     = start && !busy_r;
  assign step     = valid_r && pix_done;
  assign last_pix = (x_r == end_x_r);
  assign err_step = err_r - dy_r;

  // busy rises on start, valid one cycle later
  // valid stays up between pixels and drops with busy after the last one
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_r  <= 1'b0;
      valid_r <= 1'b0;
    end else if (load) begin
      busy_r <= 1'b1;
    end else if (busy_r && !valid_r) begin
      valid_r <= 1'b1;
    end else if (step && last_pix) begin
      busy_r  <= 1'b0;
      valid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      x_r     <= start_x;
      y_r     <= start_y;
      end_x_r <= end_x;
      err_r   <= err_init;
      dx_r    <= delta_x;
      dy_r    <= delta_y;
      yneg_r  <= ystep_neg;
      steep_r <= steep;
      color_r <= color;
      frame_r <= frame_sel;
    end else if (step && !last_pix) begin
      x_r <= x_r + line_pkg::coord_t'(1);
      // Error went negative, so y takes a step
      if (err_step < 0) begin
        y_r   <= yneg_r ? y_r - line_pkg::coord_t'(1) : y_r + line_pkg::coord_t'(1);
        err_r <= err_step + dx_r;
      end else begin
        err_r <= err_step;
      end
    end
  end

  assign busy      = busy_r;
  assign pix_valid = valid_r;

  // Undo the axis swap for the plotted position
  assign pix_col   = steep_r ? y_r : x_r;
  assign pix_row   = steep_r ? x_r : y_r;
  assign pix_color = color_r;
  assign pix_frame = frame_r;

  // Arbiter may take several cycles, the pixel must not move meanwhile
  a_pix_stable: assert property (@(posedge clk) disable iff (rst)
    (pix_valid && !pix_done) |=>
      $stable({pix_col, pix_row, pix_color, pix_frame}));

endmodule

// File: line_pkg.sv
package line_pkg;

  `include "line_defs.svh"

  // One x or y screen coordinate
  typedef logic [`LINE_COORD_W-1:0] coord_t;

  // Signed Bresenham error and deltas
  typedef logic signed [`LINE_ERR_W-1:0] err_t;

  // Pixel word, RGB in the low 24 bits, top byte zero
  typedef logic [31:0] color_t;

  // Pixel slot inside an 8-pixel burst
  typedef logic [2:0] pix_idx_t;

  // Address FIFO word
  typedef logic [`LINE_ADDR_W-1:0] mem_addr_t;

  // Active-low byte enables of one beat
  typedef logic [`LINE_MASK_W-1:0] beat_mask_t;

  // One bit per engine
  typedef logic [`LINE_NUM_ENGINES-1:0] eng_vec_t;

endpackage

// File: line_raster_top.sv
`include "line_defs.svh"

module line_raster_top (
  input  logic                 clk,
  input  logic                 rst,
  input  line_pkg::color_t     color,
  input  line_pkg::coord_t     point,
  input  logic                 color_valid,
  input  logic                 x0_valid,
  input  logic                 y0_valid,
  input  logic                 x1_valid,
  input  logic                 y1_valid,
  input  logic                 trigger,
  input  logic [31:0]          frame_base,
  input  logic                 af_full,
  input  logic                 wdf_full,
  output logic                 ready,
  output line_pkg::mem_addr_t  af_addr_din,
  output logic                 af_wr_en,
  output logic [127:0]         wdf_din,
  output line_pkg::beat_mask_t wdf_mask_din,
  output logic                 wdf_wr_en
);

  localparam int NUM_ENG = `LINE_NUM_ENGINES;

  // Setup to engines
  wire line_pkg::eng_vec_t start;
  wire line_pkg::eng_vec_t busy;
  wire line_pkg::coord_t   start_x;
  wire line_pkg::coord_t   start_y;
  wire line_pkg::coord_t   end_x;
  wire line_pkg::err_t     delta_x;
  wire line_pkg::err_t     delta_y;
  wire line_pkg::err_t     err_init;
  wire                     ystep_neg;
  wire                     steep;
  wire line_pkg::color_t   line_color;
  wire [5:0]               frame_sel;

  // Engines to arbiter
  wire line_pkg::eng_vec_t pix_valid;
  wire line_pkg::eng_vec_t pix_done;
  wire line_pkg::coord_t   pix_col   [NUM_ENG];
  wire line_pkg::coord_t   pix_row   [NUM_ENG];
  wire line_pkg::color_t   pix_color [NUM_ENG];
  wire [5:0]               pix_frame [NUM_ENG];

  line_setup i_setup (
    .clk         (clk),
    .rst         (rst),
    .color       (color),
    .point       (point),
    .color_valid (color_valid),
    .x0_valid    (x0_valid),
    .y0_valid    (y0_valid),
    .x1_valid    (x1_valid),
    .y1_valid    (y1_valid),
    .trigger     (trigger),
    .frame_base  (frame_base),
    .busy        (busy),
    .ready       (ready),
    .start       (start),
    .start_x     (start_x),
    .start_y     (start_y),
    .end_x       (end_x),
    .delta_x     (delta_x),
    .delta_y     (delta_y),
    .err_init    (err_init),
    .ystep_neg   (ystep_neg),
    .steep       (steep),
    .color_out   (line_color),
    .frame_sel   (frame_sel)
  );

  for (genvar g = 0; g < NUM_ENG; g++) begin : g_eng
    line_engine i_engine (
      .clk       (clk),
      .rst       (rst),
      .start     (start[g]),
      .start_x   (start_x),
      .start_y   (start_y),
      .end_x     (end_x),
      .delta_x   (delta_x),
      .delta_y   (delta_y),
      .err_init  (err_init),
      .ystep_neg (ystep_neg),
      .steep     (steep),
      .color     (line_color),
      .frame_sel (frame_sel),
      .pix_done  (pix_done[g]),
      .busy      (busy[g]),
      .pix_valid (pix_valid[g]),
      .pix_col   (pix_col[g]),
      .pix_row   (pix_row[g]),
      .pix_color (pix_color[g]),
      .pix_frame (pix_frame[g])
    );
  end

  line_write_arb i_arb (
    .clk          (clk),
    .rst          (rst),
    .pix_valid    (pix_valid),
    .pix_col      (pix_col),
    .pix_row      (pix_row),
    .pix_color    (pix_color),
    .pix_frame    (pix_frame),
    .af_full      (af_full),
    .wdf_full     (wdf_full),
    .pix_done     (pix_done),
    .af_addr_din  (af_addr_din),
    .af_wr_en     (af_wr_en),
    .wdf_din      (wdf_din),
    .wdf_mask_din (wdf_mask_din),
    .wdf_wr_en    (wdf_wr_en)
  );

endmodule

// File: line_setup.sv
module line_setup (
  input  logic               clk,
  input  logic               rst,
  input  line_pkg::color_t   color,
  input  line_pkg::coord_t   point,
  input  logic               color_valid,
  input  logic               x0_valid,
  input  logic               y0_valid,
  input  logic               x1_valid,
  input  logic               y1_valid,
  input  logic               trigger,
  input  logic [31:0]        frame_base,
  input  line_pkg::eng_vec_t busy,
  output logic               ready,
  output line_pkg::eng_vec_t start,
  output line_pkg::coord_t   start_x,
  output line_pkg::coord_t   start_y,
  output line_pkg::coord_t   end_x,
  output line_pkg::err_t     delta_x,
  output line_pkg::err_t     delta_y,
  output line_pkg::err_t     err_init,
  output logic               ystep_neg,
  output logic               steep,
  output line_pkg::color_t   color_out,
  output logic [5:0]         frame_sel
);

  typedef enum logic {S_IDLE, S_HOLD} state_t;

  state_t state;

  // Host-loaded endpoints and color
  line_pkg::coord_t x0_r;
  line_pkg::coord_t y0_r;
  line_pkg::coord_t x1_r;
  line_pkg::coord_t y1_r;
  line_pkg::color_t color_r;

  line_pkg::coord_t abs_dx;
  line_pkg::coord_t abs_dy;
  logic             is_steep;
  line_pkg::coord_t ax0;
  line_pkg::coord_t ay0;
  line_pkg::coord_t ax1;
  line_pkg::coord_t ay1;
  line_pkg::coord_t sx0;
  line_pkg::coord_t sy0;
  line_pkg::coord_t sx1;
  line_pkg::coord_t sy1;
  line_pkg::coord_t run_x;
  line_pkg::coord_t rise_y;

  line_pkg::eng_vec_t free_eng;
  logic               accept;

  // Strobed host registers
  always_ff @(posedge clk) begin
    if (color_valid)
      color_r <= color;
    if (x0_valid)
      x0_r <= point;
    if (y0_valid)
      y0_r <= point;
    if (x1_valid)
      x1_r <= point;
    if (y1_valid)
      y1_r <= point;
  end

  // Steep test, swaps and deltas
  always_comb begin
    abs_dx = (x1_r > x0_r) ? x1_r - x0_r : x0_r - x1_r;
    abs_dy = (y1_r > y0_r) ? y1_r - y0_r : y0_r - y1_r;
    is_steep = abs_dy > abs_dx;
    // Steep lines walk along y, so trade axes
    ax0 = is_steep ? y0_r : x0_r;
    ay0 = is_steep ? x0_r : y0_r;
    ax1 = is_steep ? y1_r : x1_r;
    ay1 = is_steep ? x1_r : y1_r;
    // Always walk toward increasing x
    if (ax0 > ax1) begin
      sx0 = ax1;
      sy0 = ay1;
      sx1 = ax0;
      sy1 = ay0;
    end else begin
      sx0 = ax0;
      sy0 = ay0;
      sx1 = ax1;
      sy1 = ay1;
    end
    run_x = sx1 - sx0;
    rise_y = (sy1 > sy0) ? sy1 - sy0 : sy0 - sy1;
  end

  assign ready  = (state == S_IDLE);
  assign accept = ready && trigger;

  // Prepared line, held until an engine takes it
  always_ff @(posedge clk) begin
    if (accept) begin
      start_x   <= sx0;
      start_y   <= sy0;
      end_x     <= sx1;
      delta_x   <= line_pkg::err_t'(run_x);
      delta_y   <= line_pkg::err_t'(rise_y);
      err_init  <= line_pkg::err_t'(run_x >> 1);
      ystep_neg <= sy0 > sy1;
      steep     <= is_steep;
      color_out <= color_r;
      frame_sel <= frame_base[27:22];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (trigger)
            state <= S_HOLD;
        end
        S_HOLD: begin
          if (|free_eng)
            state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Lowest free engine wins
  assign free_eng = ~busy;
  assign start = (state == S_HOLD) ?
                 (free_eng & (~free_eng + line_pkg::eng_vec_t'(1))) : '0;

  a_start_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(start));

  // Never hand a line to an engine that is still walking
  a_start_free: assert property (@(posedge clk) disable iff (rst)
    (start & busy) == '0);

  // Engine picks the line up and reports busy next cycle
  a_start_taken: assert property (@(posedge clk) disable iff (rst)
    (start != '0) |=> ((busy & $past(start)) == $past(start)));

endmodule

// File: line_write_arb.sv
`include "line_defs.svh"

module line_write_arb (
  input  logic                 clk,
  input  logic                 rst,
  input  line_pkg::eng_vec_t   pix_valid,
  input  line_pkg::coord_t     pix_col   [`LINE_NUM_ENGINES],
  input  line_pkg::coord_t     pix_row   [`LINE_NUM_ENGINES],
  input  line_pkg::color_t     pix_color [`LINE_NUM_ENGINES],
  input  logic [5:0]           pix_frame [`LINE_NUM_ENGINES],
  input  logic                 af_full,
  input  logic                 wdf_full,
  output line_pkg::eng_vec_t   pix_done,
  output line_pkg::mem_addr_t  af_addr_din,
  output logic                 af_wr_en,
  output logic [127:0]         wdf_din,
  output line_pkg::beat_mask_t wdf_mask_din,
  output logic                 wdf_wr_en
);

  localparam int NUM_ENG = `LINE_NUM_ENGINES;
  localparam int IDX_W   = (NUM_ENG > 1) ? $clog2(NUM_ENG) : 1;

  typedef enum logic [1:0] {S_IDLE, S_BEAT1, S_BEAT2} state_t;

  state_t state;

  logic [IDX_W-1:0] gnt_r;
  logic [IDX_W-1:0] pick;
  logic             found;
  logic             fifo_ok;

  line_pkg::coord_t     col;
  line_pkg::coord_t     row;
  line_pkg::pix_idx_t   idx;
  line_pkg::beat_mask_t lane_mask;
  line_pkg::beat_mask_t mask_lo;
  line_pkg::beat_mask_t mask_hi;

  assign fifo_ok = !af_full && !wdf_full;

  // Round robin, search starts just past the last grant
  always_comb begin
    int cand;
    pick  = gnt_r;
    found = 1'b0;
    for (int i = 1; i <= NUM_ENG; i++) begin
      cand = (int'(gnt_r) + i) % NUM_ENG;
      if (!found && pix_valid[cand]) begin
        found = 1'b1;
        pick  = IDX_W'(cand);
      end
    end
  end

  // Grant holds from beat one through beat two
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      gnt_r <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (found) begin
            gnt_r <= pick;
            state <= S_BEAT1;
          end
        end
        S_BEAT1: begin
          if (fifo_ok)
            state <= S_BEAT2;
        end
        S_BEAT2: begin
          if (fifo_ok)
            state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign af_wr_en  = (state == S_BEAT1) && fifo_ok;
  assign wdf_wr_en = (state != S_IDLE) && fifo_ok;

  always_comb begin
    pix_done        = '0;
    pix_done[gnt_r] = (state == S_BEAT2) && fifo_ok;
  end

  assign col = pix_col[gnt_r];
  assign row = pix_row[gnt_r];
  assign idx = col[2:0];

  // Burst address, 32 bytes per 8 pixels
  assign af_addr_din = {6'b0, pix_frame[gnt_r], row, col[9:3], 2'b00};
  assign wdf_din     = {4{pix_color[gnt_r]}};

  // Slot 0 sits in the top nibble of its beat
  assign lane_mask    = ~(line_pkg::beat_mask_t'(16'hF000) >> {idx[1:0], 2'b00});
  assign mask_lo      = idx[2] ? '1 : lane_mask;
  assign mask_hi      = idx[2] ? lane_mask : '1;
  assign wdf_mask_din = (state == S_BEAT2) ? mask_hi : mask_lo;

  a_af_with_wdf: assert property (@(posedge clk) disable iff (rst)
    af_wr_en |-> wdf_wr_en);

  a_no_write_full: assert property (@(posedge clk) disable iff (rst)
    (af_full || wdf_full) |-> !(af_wr_en || wdf_wr_en));

endmodule

// File: run.sh
#!/bin/sh
# Build and run the line raster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_line_raster \
  -f files.f -o sim_line_raster
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_line_raster > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The log decides the verdict
if grep -q "^Simulation PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb_line_raster.sv
module tb_line_raster;

  localparam int CLK_PERIOD    = 40;
  localparam int NUM_LINES     = 14;
  // Generous per-pixel budget under random back-pressure
  localparam int PIX_CYCLES    = 40;
  localparam int LINE_CYCLES   = 60;
  localparam int MARGIN_CYCLES = 500;

  typedef struct packed {
    line_pkg::coord_t x0;
    line_pkg::coord_t y0;
    line_pkg::coord_t x1;
    line_pkg::coord_t y1;
    line_pkg::color_t color;
    logic [31:0]      fb;
  } line_rec_t;

  logic                 clk;
  logic                 rst;
  line_pkg::color_t     color;
  line_pkg::coord_t     point;
  logic                 color_valid;
  logic                 x0_valid;
  logic                 y0_valid;
  logic                 x1_valid;
  logic                 y1_valid;
  logic                 trigger;
  logic [31:0]          frame_base;
  logic                 af_full;
  logic                 wdf_full;
  logic                 ready;
  line_pkg::mem_addr_t  af_addr_din;
  logic                 af_wr_en;
  logic [127:0]         wdf_din;
  line_pkg::beat_mask_t wdf_mask_din;
  logic                 wdf_wr_en;

  line_rec_t lines [NUM_LINES];

  // Expected pixels of each line in walk order
  line_pkg::mem_addr_t exp_addr [NUM_LINES][$];
  line_pkg::pix_idx_t  exp_idx  [NUM_LINES][$];

  int total_pix;
  int pix_seen;
  int max_busy;

  // Beat one waiting for its beat two
  logic                 beat1_pend;
  line_pkg::mem_addr_t  beat1_addr;
  line_pkg::beat_mask_t beat1_mask;
  logic [127:0]         beat1_data;

  line_raster_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .color        (color),
    .point        (point),
    .color_valid  (color_valid),
    .x0_valid     (x0_valid),
    .y0_valid     (y0_valid),
    .x1_valid     (x1_valid),
    .y1_valid     (y1_valid),
    .trigger      (trigger),
    .frame_base   (frame_base),
    .af_full      (af_full),
    .wdf_full     (wdf_full),
    .ready        (ready),
    .af_addr_din  (af_addr_din),
    .af_wr_en     (af_wr_en),
    .wdf_din      (wdf_din),
    .wdf_mask_din (wdf_mask_din),
    .wdf_wr_en    (wdf_wr_en)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_addr(string name, line_pkg::mem_addr_t got, line_pkg::mem_addr_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_mask(string name, line_pkg::beat_mask_t got, line_pkg::beat_mask_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_color(string name, line_pkg::color_t got, line_pkg::color_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  function automatic int abs_int(int v);
    return (v < 0) ? -v : v;
  endfunction

  // Frame bits 27..22, then row, then 32-byte burst within the row
  function automatic line_pkg::mem_addr_t expected_addr(logic [31:0] fb, int col, int row);
    int unsigned a;
    a = ((fb >> 22) & 32'h3F) * 32'd524288 + 32'(row) * 32'd512 + 32'(col / 8) * 32'd4;
    return line_pkg::mem_addr_t'(a);
  endfunction

  function automatic line_pkg::beat_mask_t expected_mask(line_pkg::pix_idx_t idx, logic second);
    line_pkg::beat_mask_t m;
    int top;
    m = '1;
    top = 15 - 4 * int'(idx[1:0]);
    // Pixel k of a beat clears nibble 3-k
    if (idx[2] == second)
      m[top -: 4] = 4'h0;
    return m;
  endfunction

  task automatic fill_table();
    lines[0]  = '{10'd3, 10'd5, 10'd20, 10'd9, 32'h0011_2233, 32'h0FC0_0000};
    lines[1]  = '{10'd40, 10'd12, 10'd10, 10'd2, 32'h0044_5566, 32'h0540_0000};
    lines[2]  = '{10'd100, 10'd50, 10'd107, 10'd50, 32'h0077_8899, 32'hF000_0000};
    lines[3]  = '{10'd215, 10'd7, 10'd200, 10'd7, 32'h00AA_BBCC, 32'h0A5F_FFFF};
    lines[4]  = '{10'd10, 10'd10, 10'd14, 10'd30, 32'h00DD_EEFF, 32'h0000_0000};
    lines[5]  = '{10'd50, 10'd40, 10'd45, 10'd5, 32'h0012_3456, 32'h0FFF_FFFF};
    lines[6]  = '{10'd33, 10'd0, 10'd33, 10'd9, 32'h0065_4321, 32'h0280_0000};
    lines[7]  = '{10'd1023, 10'd20, 10'd1023, 10'd3, 32'h00FE_DCBA, 32'h0D40_1234};
    lines[8]  = '{10'd5, 10'd5, 10'd5, 10'd5, 32'h0001_0203, 32'h0100_0000};
    lines[9]  = '{10'd0, 10'd0, 10'd7, 10'd7, 32'h0004_0506, 32'h0400_0000};
    lines[10] = '{10'd600, 10'd900, 10'd700, 10'd880, 32'h0007_0809, 32'h0840_0000};
    lines[11] = '{10'd300, 10'd100, 10'd290, 10'd140, 32'h000A_0B0C, 32'h0C00_0000};
    lines[12] = '{10'd8, 10'd1, 10'd0, 10'd2, 32'h000D_0E0F, 32'h0FC0_0000};
    lines[13] = '{10'd512, 10'd511, 10'd520, 10'd530, 32'h0010_2030, 32'h0540_0000};
  endtask

  // Reference Bresenham walk of one table entry
  task automatic model_line(int n);
    int x0;
    int y0;
    int x1;
    int y1;
    int t;
    int dx;
    int dy;
    int err;
    int ystep;
    int y;
    int col;
    int row;
    logic steep_l;
    x0 = int'(lines[n].x0);
    y0 = int'(lines[n].y0);
    x1 = int'(lines[n].x1);
    y1 = int'(lines[n].y1);
    steep_l = abs_int(y1 - y0) > abs_int(x1 - x0);
    if (steep_l) begin
      t = x0;
      x0 = y0;
      y0 = t;
      t = x1;
      x1 = y1;
      y1 = t;
    end
    if (x0 > x1) begin
      t = x0;
      x0 = x1;
      x1 = t;
      t = y0;
      y0 = y1;
      y1 = t;
    end
    dx = x1 - x0;
    dy = abs_int(y1 - y0);
    err = dx / 2;
    ystep = (y0 > y1) ? -1 : 1;
    y = y0;
    for (int x = x0; x <= x1; x++) begin
      col = steep_l ? y : x;
      row = steep_l ? x : y;
      exp_addr[n].push_back(expected_addr(lines[n].fb, col, row));
      exp_idx[n].push_back(line_pkg::pix_idx_t'(col % 8));
      err = err - dy;
      if (err < 0) begin
        y = y + ystep;
        err = err + dx;
      end
    end
  endtask

  task automatic load_line(int n);
    @(posedge clk);
    color       <= lines[n].color;
    color_valid <= 1'b1;
    point       <= lines[n].x0;
    x0_valid    <= 1'b1;
    @(posedge clk);
    color_valid <= 1'b0;
    x0_valid    <= 1'b0;
    point       <= lines[n].y0;
    y0_valid    <= 1'b1;
    @(posedge clk);
    y0_valid <= 1'b0;
    point    <= lines[n].x1;
    x1_valid <= 1'b1;
    @(posedge clk);
    x1_valid <= 1'b0;
    point    <= lines[n].y1;
    y1_valid <= 1'b1;
    @(posedge clk);
    y1_valid <= 1'b0;
  endtask

  task automatic fire_trigger(int n);
    @(negedge clk);
    while (!ready)
      @(negedge clk);
    @(posedge clk);
    trigger    <= 1'b1;
    frame_base <= lines[n].fb;
    @(posedge clk);
    trigger <= 1'b0;
    @(negedge clk);
    if (ready)
      stop_with_failure("ready stayed high after an accepted trigger");
  endtask

  // Pair beat two with the held beat one and attribute it by color
  task automatic match_pixel(line_pkg::beat_mask_t mask2, logic [127:0] data2);
    int n;
    line_pkg::color_t c;
    line_pkg::mem_addr_t ea;
    line_pkg::pix_idx_t ei;
    c = line_pkg::color_t'(beat1_data[31:0]);
    n = -1;
    for (int i = 0; i < NUM_LINES; i++)
      if (lines[i].color == c)
        n = i;
    if (n < 0)
      stop_with_failure($sformatf("beat one carries unknown color 0x%h", c));
    for (int k = 0; k < 4; k++) begin
      check_color($sformatf("wdf_din beat one lane %0d", k), beat1_data[32*k +: 32],
                  lines[n].color);
      check_color($sformatf("wdf_din beat two lane %0d", k), data2[32*k +: 32],
                  lines[n].color);
    end
    if (exp_addr[n].size() == 0)
      stop_with_failure($sformatf("extra pixel written for line %0d", n));
    ea = exp_addr[n].pop_front();
    ei = exp_idx[n].pop_front();
    check_addr("af_addr_din", beat1_addr, ea);
    check_mask("wdf_mask_din beat one", beat1_mask, expected_mask(ei, 1'b0));
    check_mask("wdf_mask_din beat two", mask2, expected_mask(ei, 1'b1));
    pix_seen++;
  endtask

  // FIFO write monitor sampling settled outputs at the falling edge
  always @(negedge clk) begin
    if (rst === 1'b0) begin
      if ($countones(i_dut.busy) > max_busy)
        max_busy = $countones(i_dut.busy);
      if ((af_wr_en || wdf_wr_en) && (af_full || wdf_full))
        stop_with_failure("write enable high while a FIFO full flag is high");
      if (af_wr_en) begin
        if (!wdf_wr_en)
          stop_with_failure("af_wr_en without wdf_wr_en");
        if (beat1_pend)
          stop_with_failure("af_wr_en on beat two or beat one repeated");
        beat1_pend = 1'b1;
        beat1_addr = af_addr_din;
        beat1_mask = wdf_mask_din;
        beat1_data = wdf_din;
      end else if (wdf_wr_en) begin
        if (!beat1_pend)
          stop_with_failure("beat two without a preceding beat one");
        beat1_pend = 1'b0;
        match_pixel(wdf_mask_din, wdf_din);
      end
    end
  end

  // Random back-pressure on both FIFOs
  initial begin
    af_full  = 1'b0;
    wdf_full = 1'b0;
    void'($urandom(85602));
    wait (rst === 1'b0);
    forever begin
      @(posedge clk);
      af_full  <= ($urandom % 32'd4) == 32'd0;
      wdf_full <= ($urandom % 32'd5) == 32'd0;
    end
  end

  initial begin
    int budget;
    wait (total_pix > 0);
    budget = total_pix * PIX_CYCLES + NUM_LINES * LINE_CYCLES + MARGIN_CYCLES;
    #(budget * CLK_PERIOD);
    stop_with_failure($sformatf("timeout after %0d cycles, %0d of %0d pixels written",
                                budget, pix_seen, total_pix));
  end

  task automatic finish_run();
    int left;
    int min_busy;
    left = 0;
    for (int i = 0; i < NUM_LINES; i++)
      left += exp_addr[i].size();
    min_busy = ($bits(line_pkg::eng_vec_t) > 1) ? 2 : 1;
    if (left == 0 && !beat1_pend && max_busy >= min_busy) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stop_with_failure($sformatf("%0d pixels missing, beat one pending %0b, peak busy %0d",
                                  left, beat1_pend, max_busy));
    end
  endtask

  initial begin
    rst         = 1'b1;
    color       = '0;
    point       = '0;
    color_valid = 1'b0;
    x0_valid    = 1'b0;
    y0_valid    = 1'b0;
    x1_valid    = 1'b0;
    y1_valid    = 1'b0;
    trigger     = 1'b0;
    frame_base  = '0;
    pix_seen    = 0;
    max_busy    = 0;
    beat1_pend  = 1'b0;
    fill_table();
    for (int i = 0; i < NUM_LINES; i++) begin
      model_line(i);
      total_pix += exp_addr[i].size();
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (!ready || af_wr_en || wdf_wr_en)
      stop_with_failure("outputs not idle after reset");
    // Next line loads while earlier ones still walk
    for (int i = 0; i < NUM_LINES; i++) begin
      load_line(i);
      fire_trigger(i);
    end
    while (pix_seen < total_pix)
      @(negedge clk);
    // Quiet time so a duplicate write still shows up
    repeat (50) @(negedge clk);
    finish_run();
  end

endmodule
